//--- bench/tb_cache_subsystem.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module tb_cache_subsystem
    import cache_pkg::*;
();

    localparam int CLK_HALF      = 4;
    localparam int STALL_TIMEOUT = 200;
    localparam int NUM_RANDOM    = 600;
    localparam int MEM_WORDS     = 1 << `MEM_ADDR_W;
    localparam int LINE_WORDS    = `CACHE_LINES * `WORDS_PER_LINE;

    logic       clk;
    logic       rst;
    word_addr_t ic_addr;
    logic       dc_read;
    logic       dc_write;
    word_addr_t dc_addr;
    data_t      dc_wdata;
    byte_en_t   dc_byte_w_en;
    data_t      ic_rdata;
    data_t      dc_rdata;
    logic       stall;

    // Reference memory as the CPU should see it
    data_t                   model_mem [MEM_WORDS];
    // Instruction cache lines keep what they held at fill time
    data_t                   ic_line_data [LINE_WORDS];
    tag_t                    ic_tags [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] ic_valids;
    tag_t                    dc_tags [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] dc_valids;
    logic [`CACHE_LINES-1:0] dc_dirties;

    int seed;
    int data_errors;
    int count_errors;
    int timeout_errors;
    int accesses;
    int reset_stall_cycles;

    cache_subsystem u_cache_subsystem (
        .clk          (clk),
        .rst          (rst),
        .ic_addr      (ic_addr),
        .dc_read      (dc_read),
        .dc_write     (dc_write),
        .dc_addr      (dc_addr),
        .dc_wdata     (dc_wdata),
        .dc_byte_w_en (dc_byte_w_en),
        .ic_rdata     (ic_rdata),
        .dc_rdata     (dc_rdata),
        .stall        (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address split and model updates
    ////////////////////////////////////////////////////////////

    function automatic tag_t tag_of(input word_addr_t a);
        return a[WORD_W+INDEX_W +: TAG_W];
    endfunction

    function automatic index_t index_of(input word_addr_t a);
        return a[WORD_W +: INDEX_W];
    endfunction

    task automatic apply_store(input word_addr_t a, input data_t wd, input byte_en_t be);
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (be[b]) begin
                model_mem[a][8*b +: 8] = wd[8*b +: 8];
            end
        end
    endtask

    task automatic load_icache_line(input word_addr_t a);
        index_t     idx;
        word_addr_t src;
        idx = index_of(a);
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            src = {a[`MEM_ADDR_W-1:WORD_W], word_sel_t'(w)};
            ic_line_data[{idx, word_sel_t'(w)}] = model_mem[src];
        end
        ic_tags[idx]   = tag_of(a);
        ic_valids[idx] = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input data_t got, input data_t expected);
        if (got !== expected) begin
            data_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            count_errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One CPU request, held until stall falls
    ////////////////////////////////////////////////////////////

    task automatic run_access(
        input word_addr_t ia,
        input logic       rd,
        input logic       wr,
        input word_addr_t da,
        input data_t      wd,
        input byte_en_t   be
    );
        index_t ii;
        index_t di;
        logic   ic_miss;
        logic   dc_miss;
        int     phases;
        int     expected_stall;
        int     stall_cycles;
        if (timeout_errors != 0) begin
            return;
        end
        ii      = index_of(ia);
        di      = index_of(da);
        ic_miss = !(ic_valids[ii] && ic_tags[ii] == tag_of(ia));
        dc_miss = (rd || wr) && !(dc_valids[di] && dc_tags[di] == tag_of(da));

        // One phase per refill plus one for a dirty victim
        phases = 0;
        if (ic_miss) begin
            phases++;
        end
        if (dc_miss) begin
            phases++;
            if (dc_dirties[di]) begin
                phases++;
            end
        end
        expected_stall = (phases == 0) ? 0 : 1 + `WORDS_PER_LINE * phases;

        ic_addr      = ia;
        dc_read      = rd;
        dc_write     = wr;
        dc_addr      = da;
        dc_wdata     = wd;
        dc_byte_w_en = be;
        accesses++;

        stall_cycles = 0;
        @(negedge clk);
        while (stall !== 1'b0 && stall_cycles < STALL_TIMEOUT) begin
            stall_cycles++;
            @(negedge clk);
        end

        if (stall !== 1'b0) begin
            timeout_errors++;
            $display("Timeout at %0t: stall stayed high for %0d cycles on access %0d",
                     $time, STALL_TIMEOUT, accesses);
        end else begin
            if (ic_miss) begin
                // A store that hits lands in the detect cycle before the fetch line fills
                if (wr && !dc_miss) begin
                    apply_store(da, wd, be);
                end
                load_icache_line(ia);
            end
            if (dc_miss) begin
                dc_tags[di]    = tag_of(da);
                dc_valids[di]  = 1'b1;
                dc_dirties[di] = 1'b0;
            end
            check_count("stall cycles", stall_cycles, expected_stall);
            check_data("ic_rdata", ic_rdata, ic_line_data[{ii, ia[WORD_W-1:0]}]);
            if (rd) begin
                check_data("dc_rdata", dc_rdata, model_mem[da]);
            end
            if (wr) begin
                apply_store(da, wd, be);
                dc_dirties[di] = 1'b1;
            end
        end

        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic run_directed();
        // First fetch on empty caches must miss
        run_access(12'h000, 1'b0, 1'b0, 12'h000, '0, '0);
        // Store then evict through a conflicting read and reload
        run_access(12'h000, 1'b0, 1'b1, 12'h0a3, 32'hcafe_f00d, 4'b1111);
        run_access(12'h000, 1'b1, 1'b0, 12'h2a3, '0, '0);
        run_access(12'h000, 1'b1, 1'b0, 12'h0a3, '0, '0);
        // Partial store merge
        run_access(12'h000, 1'b0, 1'b1, 12'h0a5, 32'h1122_3344, 4'b0101);
        run_access(12'h000, 1'b1, 1'b0, 12'h0a5, '0, '0);
        // Fetch of a line held dirty in the data cache
        run_access(12'h000, 1'b0, 1'b1, 12'h150, 32'h0bad_c0de, 4'b1111);
        run_access(12'h150, 1'b0, 1'b0, 12'h150, '0, '0);
        // Double miss with dirty victim and the victim line read back
        run_access(12'h7f8, 1'b1, 1'b0, 12'h3d0, '0, '0);
        run_access(12'h7f8, 1'b1, 1'b0, 12'h150, '0, '0);
    endtask

    task automatic random_access();
        logic [31:0] r_addr;
        logic [31:0] r_fetch;
        logic [31:0] r_op;
        data_t       wd;
        word_addr_t  ia;
        word_addr_t  da;
        r_addr  = $random(seed);
        r_fetch = $random(seed);
        r_op    = $random(seed);
        wd      = $random(seed);

        // Four tags over four indexes keeps lines colliding
        da = {3'b000, r_addr[1:0], 2'b00, r_addr[3:2], r_addr[6:4]};
        if (r_addr[9:8] == 2'b00) begin
            da = r_addr[21:10];
        end

        case (r_fetch[1:0])
            2'b00: ia = da;
            2'b01: ia = r_fetch[13:2];
            default: ia = {3'b000, r_fetch[3:2], 2'b00, r_fetch[5:4], r_fetch[8:6]};
        endcase

        run_access(ia, r_op[1:0] == 2'b01, r_op[1], da, wd, r_op[5:2]);
    endtask

    initial begin
        seed               = 32'h7d71;
        data_errors        = 0;
        count_errors       = 0;
        timeout_errors     = 0;
        accesses           = 0;
        reset_stall_cycles = 0;

        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[word_addr_t'(i)] = data_t'(i) ^ `MEM_INIT_KEY;
        end
        ic_valids  = '0;
        dc_valids  = '0;
        dc_dirties = '0;

        rst          = 1'b1;
        ic_addr      = '0;
        dc_read      = 1'b0;
        dc_write     = 1'b0;
        dc_addr      = '0;
        dc_wdata     = '0;
        dc_byte_w_en = '0;

        @(posedge clk);
        // Stall stays low once the first reset edge has cleared the caches
        repeat (2) begin
            @(negedge clk);
            if (stall !== 1'b0) begin
                reset_stall_cycles++;
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        check_count("stall cycles in reset", reset_stall_cycles, 0);

        run_directed();
        for (int n = 0; n < NUM_RANDOM && timeout_errors == 0; n++) begin
            random_access();
        end

        $display("Errors: data %0d, stall length %0d, timeout %0d over %0d accesses",
                 data_errors, count_errors, timeout_errors, accesses);
        if (data_errors + count_errors + timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/bash
# Build the cache subsystem testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_cache_subsystem \
    -f vlog.f \
    -o tb_cache_subsystem

./obj_dir/tb_cache_subsystem | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim: testbench reported failure"
    exit 1
fi

echo "run_sim: testbench finished without failure"

//--- verilog/cache_control.sv
`timescale 1ns/1ps

module cache_control
    import cache_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          dc_read,
    input  logic          dc_write_in,
    input  word_sel_t     ic_word_sel_in,
    input  word_sel_t     dc_word_sel_in,
    input  byte_en_t      dc_byte_w_en_in,
    input  logic          ic_hit,
    input  logic          ic_valid,
    input  logic          dc_hit,
    input  logic          dc_valid,
    input  logic          dc_dirty,
    output logic          ic_enable,
    output logic          ic_cmp,
    output logic          ic_write,
    output logic          ic_valid_out,
    output word_sel_t     ic_word_sel,
    output byte_en_t      ic_byte_w_en,
    output logic          dc_enable,
    output logic          dc_cmp,
    output logic          dc_write,
    output logic          dc_valid_out,
    output word_sel_t     dc_word_sel,
    output byte_en_t      dc_byte_w_en,
    output logic          ram_en,
    output logic          ram_write,
    output ram_addr_sel_t ram_addr_sel,
    output logic          stall
);

    cache_state_t state;
    cache_state_t state_next;
    word_sel_t    counter;
    word_sel_t    counter_next;
    logic         last_word;
    logic         dc_access;
    logic         ic_miss;
    logic         dc_miss;

    assign last_word = (counter == '1);
    assign dc_access = dc_read | dc_write_in;
    assign ic_miss   = !(ic_hit && ic_valid);
    assign dc_miss   = dc_access && !(dc_hit && dc_valid);

    ////////////////////////////////////////////////////////////
    // Next status and per-word cache controls
    ////////////////////////////////////////////////////////////

    always_comb begin
        ic_enable    = 1'b0;
        ic_cmp       = 1'b0;
        ic_write     = 1'b0;
        ic_valid_out = 1'b0;
        ic_word_sel  = counter;
        ic_byte_w_en = '0;
        dc_enable    = 1'b0;
        dc_cmp       = 1'b0;
        dc_write     = 1'b0;
        dc_valid_out = 1'b0;
        dc_word_sel  = counter;
        dc_byte_w_en = '0;
        ram_en       = 1'b0;
        ram_write    = 1'b0;
        ram_addr_sel = IC_LINE;
        state_next   = state;
        counter_next = counter + 1'b1;

        case (state)
            NORMAL: begin
                // CPU accesses go straight through in compare mode
                ic_enable    = 1'b1;
                ic_cmp       = 1'b1;
                ic_word_sel  = ic_word_sel_in;
                dc_enable    = dc_access;
                dc_cmp       = 1'b1;
                dc_write     = dc_write_in;
                dc_word_sel  = dc_word_sel_in;
                dc_byte_w_en = dc_byte_w_en_in;
                counter_next = '0;
                if (dc_miss && ic_miss) begin
                    state_next = dc_dirty ? DOUBLE_MISS_D : DOUBLE_MISS;
                end else if (dc_miss) begin
                    state_next = dc_dirty ? DC_MISS_D : DC_MISS;
                end else if (ic_miss) begin
                    state_next = IC_MISS;
                end
            end
            IC_MISS, DOUBLE_MISS: begin
                ic_enable    = 1'b1;
                ic_write     = 1'b1;
                ic_valid_out = 1'b1;
                ic_byte_w_en = '1;
                // Data cache supplies the fetch line when it holds it
                dc_enable    = 1'b1;
                dc_cmp       = 1'b1;
                ram_en       = !(dc_hit && dc_valid);
                ram_addr_sel = IC_LINE;
                if (last_word) begin
                    state_next = (state == DOUBLE_MISS) ? DC_MISS : NORMAL;
                end
            end
            DC_MISS: begin
                dc_enable    = 1'b1;
                dc_write     = 1'b1;
                dc_valid_out = 1'b1;
                dc_byte_w_en = '1;
                ram_en       = 1'b1;
                ram_addr_sel = DC_LINE;
                if (last_word) begin
                    state_next = NORMAL;
                end
            end
            DC_MISS_D, DOUBLE_MISS_D: begin
                // Victim word read out of the data cache into memory
                dc_enable    = 1'b1;
                ram_en       = 1'b1;
                ram_write    = 1'b1;
                ram_addr_sel = DC_VICTIM;
                if (last_word) begin
                    state_next = (state == DOUBLE_MISS_D) ? DOUBLE_MISS : DC_MISS;
                end
            end
            default: begin
                state_next = NORMAL;
            end
        endcase

        // Counter parks at the last word while idle
        if (state_next == NORMAL) begin
            counter_next = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= NORMAL;
            counter <= '1;
        end else begin
            state   <= state_next;
            counter <= counter_next;
        end
    end

    // Held from the detecting cycle through the last refill word
    assign stall = !rst && ((state != NORMAL) || (state_next != NORMAL));

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_idle_counter: assert property (
        @(posedge clk) disable iff (rst)
        (state == NORMAL) |-> (counter == '1)
    );

    a_write_back_only: assert property (
        @(posedge clk) disable iff (rst)
        ram_write |-> (state inside {DC_MISS_D, DOUBLE_MISS_D})
    );

endmodule

//--- verilog/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////

// Words per line, one refill cycle each
`define WORDS_PER_LINE 8

// Lines per cache, both caches direct mapped
`define CACHE_LINES 16

////////////////////////////////////////////////////////////
// Main memory
////////////////////////////////////////////////////////////

// Word address width, 4096 words
`define MEM_ADDR_W 12

`define DATA_W 32

// Every memory word powers up as its address xor this key
`define MEM_INIT_KEY 32'h5a3c_96e1

`endif

//--- verilog/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    // Address split, tag above index above word select
    localparam int WORD_W  = $clog2(`WORDS_PER_LINE);
    localparam int INDEX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W   = `MEM_ADDR_W - INDEX_W - WORD_W;

    typedef logic [`MEM_ADDR_W-1:0] word_addr_t;
    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`DATA_W/8-1:0]   byte_en_t;
    typedef logic [WORD_W-1:0]      word_sel_t;
    typedef logic [INDEX_W-1:0]     index_t;
    typedef logic [TAG_W-1:0]       tag_t;

    // Memory address source during refill and write-back
    typedef logic [1:0] ram_addr_sel_t;

    localparam ram_addr_sel_t IC_LINE   = 2'b00;
    localparam ram_addr_sel_t DC_LINE   = 2'b01;
    localparam ram_addr_sel_t DC_VICTIM = 2'b11;

    // Controller status, _D states write back a dirty victim
    typedef enum logic [2:0] {
        NORMAL,
        IC_MISS,
        DC_MISS,
        DC_MISS_D,
        DOUBLE_MISS,
        DOUBLE_MISS_D
    } cache_state_t;

endpackage

//--- verilog/cache_store.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_store
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      cmp,
    input  logic      write,
    input  logic      valid_in,
    input  index_t    index,
    input  tag_t      tag,
    input  word_sel_t word_sel,
    input  byte_en_t  byte_w_en,
    input  data_t     wdata,
    output data_t     rdata,
    output logic      hit,
    output logic      valid,
    output logic      dirty,
    output tag_t      victim_tag
);

    localparam int LINE_WORDS = `CACHE_LINES * `WORDS_PER_LINE;

    data_t                     data_mem [LINE_WORDS];
    tag_t                      tag_mem  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]   valid_bits;
    logic [`CACHE_LINES-1:0]   dirty_bits;
    logic [INDEX_W+WORD_W-1:0] word_addr;
    logic                      cmp_write;
    logic                      fill_write;

    assign word_addr = {index, word_sel};

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign rdata      = data_mem[word_addr];
    assign victim_tag = tag_mem[index];
    assign hit        = cmp && (tag_mem[index] == tag);
    assign valid      = valid_bits[index];
    assign dirty      = dirty_bits[index];

    // Store only lands on a resident line
    assign cmp_write  = enable && write && cmp && hit && valid;
    assign fill_write = enable && write && !cmp;

    ////////////////////////////////////////////////////////////
    // Array updates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cmp_write || fill_write) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (byte_w_en[b]) begin
                    data_mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_write) begin
            // Fresh line is clean
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= 1'b0;
        end else if (cmp_write) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    // Controller never asks for a write on an idle cache
    a_write_needs_enable: assert property (
        @(posedge clk) disable iff (rst)
        write |-> enable
    );

endmodule

//--- verilog/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_addr_t ic_addr,
    input  logic       dc_read,
    input  logic       dc_write,
    input  word_addr_t dc_addr,
    input  data_t      dc_wdata,
    input  byte_en_t   dc_byte_w_en,
    output data_t      ic_rdata,
    output data_t      dc_rdata,
    output logic       stall
);

    tag_t          ic_tag;
    index_t        ic_index;
    word_sel_t     ic_word;
    tag_t          dc_tag;
    index_t        dc_index;
    word_sel_t     dc_word;
    tag_t          dc_lookup_tag;
    index_t        dc_lookup_index;
    tag_t          victim_tag;
    data_t         fill_data;
    data_t         dc_store_wdata;

    logic          ic_en;
    logic          ic_cmp;
    logic          ic_wr;
    logic          ic_fill_valid;
    word_sel_t     ic_sel;
    byte_en_t      ic_be;
    logic          ic_hit;
    logic          ic_valid;

    logic          dc_en;
    logic          dc_cmp;
    logic          dc_wr;
    logic          dc_fill_valid;
    word_sel_t     dc_sel;
    byte_en_t      dc_be;
    logic          dc_hit;
    logic          dc_valid;
    logic          dc_dirty;

    logic          ram_en;
    logic          ram_write;
    ram_addr_sel_t ram_addr_sel;

    ////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////

    assign ic_word  = ic_addr[WORD_W-1:0];
    assign ic_index = ic_addr[WORD_W +: INDEX_W];
    assign ic_tag   = ic_addr[WORD_W+INDEX_W +: TAG_W];
    assign dc_word  = dc_addr[WORD_W-1:0];
    assign dc_index = dc_addr[WORD_W +: INDEX_W];
    assign dc_tag   = dc_addr[WORD_W+INDEX_W +: TAG_W];

    // Data cache looks up the fetch line while the icache fills
    assign dc_lookup_index = ic_wr ? ic_index : dc_index;
    assign dc_lookup_tag   = ic_wr ? ic_tag : dc_tag;

    // CPU stores in compare mode, refill words otherwise
    assign dc_store_wdata = dc_cmp ? dc_wdata : fill_data;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    cache_control u_cache_control (
        .clk             (clk),
        .rst             (rst),
        .dc_read         (dc_read),
        .dc_write_in     (dc_write),
        .ic_word_sel_in  (ic_word),
        .dc_word_sel_in  (dc_word),
        .dc_byte_w_en_in (dc_byte_w_en),
        .ic_hit          (ic_hit),
        .ic_valid        (ic_valid),
        .dc_hit          (dc_hit),
        .dc_valid        (dc_valid),
        .dc_dirty        (dc_dirty),
        .ic_enable       (ic_en),
        .ic_cmp          (ic_cmp),
        .ic_write        (ic_wr),
        .ic_valid_out    (ic_fill_valid),
        .ic_word_sel     (ic_sel),
        .ic_byte_w_en    (ic_be),
        .dc_enable       (dc_en),
        .dc_cmp          (dc_cmp),
        .dc_write        (dc_wr),
        .dc_valid_out    (dc_fill_valid),
        .dc_word_sel     (dc_sel),
        .dc_byte_w_en    (dc_be),
        .ram_en          (ram_en),
        .ram_write       (ram_write),
        .ram_addr_sel    (ram_addr_sel),
        .stall           (stall)
    );

    cache_store u_icache (
        .clk        (clk),
        .rst        (rst),
        .enable     (ic_en),
        .cmp        (ic_cmp),
        .write      (ic_wr),
        .valid_in   (ic_fill_valid),
        .index      (ic_index),
        .tag        (ic_tag),
        .word_sel   (ic_sel),
        .byte_w_en  (ic_be),
        .wdata      (fill_data),
        .rdata      (ic_rdata),
        .hit        (ic_hit),
        .valid      (ic_valid),
        .dirty      (),
        .victim_tag ()
    );

    cache_store u_dcache (
        .clk        (clk),
        .rst        (rst),
        .enable     (dc_en),
        .cmp        (dc_cmp),
        .write      (dc_wr),
        .valid_in   (dc_fill_valid),
        .index      (dc_lookup_index),
        .tag        (dc_lookup_tag),
        .word_sel   (dc_sel),
        .byte_w_en  (dc_be),
        .wdata      (dc_store_wdata),
        .rdata      (dc_rdata),
        .hit        (dc_hit),
        .valid      (dc_valid),
        .dirty      (dc_dirty),
        .victim_tag (victim_tag)
    );

    line_memory u_line_memory (
        .clk          (clk),
        .ram_en       (ram_en),
        .ram_write    (ram_write),
        .ram_addr_sel (ram_addr_sel),
        .ic_addr      (ic_addr),
        .dc_addr      (dc_addr),
        .victim_tag   (victim_tag),
        .word_sel     (dc_sel),
        .dc_rdata     (dc_rdata),
        .fill_data    (fill_data)
    );

endmodule

//--- verilog/line_memory.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module line_memory
    import cache_pkg::*;
(
    input  logic          clk,
    input  logic          ram_en,
    input  logic          ram_write,
    input  ram_addr_sel_t ram_addr_sel,
    input  word_addr_t    ic_addr,
    input  word_addr_t    dc_addr,
    input  tag_t          victim_tag,
    input  word_sel_t     word_sel,
    input  data_t         dc_rdata,
    output data_t         fill_data
);

    localparam int MEM_WORDS = 1 << `MEM_ADDR_W;

    data_t      mem [MEM_WORDS];
    word_addr_t ram_addr;

    ////////////////////////////////////////////////////////////
    // Refill address
    ////////////////////////////////////////////////////////////

    // Line base from the selected source, word from the refill counter
    always_comb begin
        case (ram_addr_sel)
            DC_LINE: begin
                ram_addr = {dc_addr[`MEM_ADDR_W-1:WORD_W], word_sel};
            end
            DC_VICTIM: begin
                ram_addr = {victim_tag, dc_addr[WORD_W +: INDEX_W], word_sel};
            end
            default: begin
                ram_addr = {ic_addr[`MEM_ADDR_W-1:WORD_W], word_sel};
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = data_t'(i) ^ `MEM_INIT_KEY;
        end
    end

    // Write-back word comes out of the data cache
    always @(posedge clk) begin
        if (ram_en && ram_write) begin
            mem[ram_addr] <= dc_rdata;
        end
    end

    // With memory off the data cache feeds the instruction fill
    assign fill_data = ram_en ? mem[ram_addr] : dc_rdata;

endmodule

//--- vlog.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_control.sv
verilog/cache_store.sv
verilog/line_memory.sv
verilog/cache_subsystem.sv
bench/tb_cache_subsystem.sv
